// File: spi_accel_macros.svh
`ifndef SPI_ACCEL_MACROS_SVH
`define SPI_ACCEL_MACROS_SVH

// ================================================
// SPI framing
// ================================================

// Bits per SPI byte, shifted MSB first
`define SPI_BYTE_W 8

// ================================================
// Buffer and result sizes, in bytes
// ================================================

`define PATCH_BYTES 25      // 5x5 patch, one byte per pixel
`define WEIGHTS_BYTES 250   // 5 kernels of 25 weights, two bytes each
`define BIASES_BYTES 10     // 5 biases, two bytes each
`define RESULTS_BYTES 10    // 5 results, two bytes each

// Data byte counter, wide enough to reach 250
`define BYTE_CNT_W 9

`endif

// File: spi_proto_pkg.sv
`include "spi_accel_macros.svh"

package spi_proto_pkg;

    // ================================================
    // Command opcodes, first byte of every frame
    // ================================================
    typedef enum logic [`SPI_BYTE_W-1:0] {
        CMD_WRITE_WEIGHTS = 8'h01,  // 250 weight bytes follow
        CMD_WRITE_PATCH   = 8'h02,  // 25 patch bytes follow
        CMD_WRITE_BIASES  = 8'h03,  // 10 bias bytes follow
        CMD_START_PROC    = 8'h10,  // One start pulse to the wrapper
        CMD_READ_STATUS   = 8'h20,  // Turnaround, then done/busy byte
        CMD_READ_RESULTS  = 8'h30   // Turnaround, then 10 result bytes
    } spi_cmd_e;

    // ================================================
    // Command controller states
    // ================================================
    typedef enum logic [1:0] {
        ST_IDLE    = 2'd0,  // Waiting for the command byte
        ST_RX_DATA = 2'd1,  // Storing write data
        ST_TX_DATA = 2'd2,  // Staging reply bytes
        ST_DONE    = 2'd3   // Rest of frame ignored
    } ctrl_state_e;

endpackage

// File: conv_buf_pkg.sv
`include "spi_accel_macros.svh"

package conv_buf_pkg;

    // Target buffer of a write frame
    typedef enum logic [1:0] {
        BUF_NONE    = 2'd0,
        BUF_PATCH   = 2'd1,
        BUF_WEIGHTS = 2'd2,
        BUF_BIASES  = 2'd3
    } buf_sel_e;

    // ================================================
    // Packed buffer images, byte 0 in the top byte
    // ================================================

    // Element [N-1] sits at the MSB end and holds byte 0
    typedef logic [`PATCH_BYTES-1:0][`SPI_BYTE_W-1:0] patch_vec_t;

    typedef logic [`WEIGHTS_BYTES-1:0][`SPI_BYTE_W-1:0] weights_vec_t;

    typedef logic [`BIASES_BYTES-1:0][`SPI_BYTE_W-1:0] biases_vec_t;

    // Results from the wrapper, same byte order
    typedef logic [`RESULTS_BYTES-1:0][`SPI_BYTE_W-1:0] results_vec_t;

endpackage

// File: spi_rx_shifter.sv
`timescale 1ns/10ps
`include "spi_accel_macros.svh"

module spi_rx_shifter (
    input  logic                   sclk_spi,      // SPI clock, mode 0
    input  logic                   cs_n_spi,      // Frame select, high clears
    input  logic                   mosi_spi,      // Serial data from master
    output logic [`SPI_BYTE_W-1:0] rx_byte,       // Last complete byte
    output logic                   rx_byte_valid  // One cycle per byte
);

    localparam int BIT_W = $clog2(`SPI_BYTE_W);

    logic [BIT_W-1:0]       bit_cnt;   // Counts 7 down to 0
    logic [`SPI_BYTE_W-2:0] shift_q;   // Upper bits of the byte in flight

    // ================================================
    // MOSI shift register
    // ================================================

    // Only the first seven bits need holding, bit 0 goes straight to rx_byte
    always_ff @(posedge sclk_spi) begin
        shift_q <= {shift_q[`SPI_BYTE_W-3:0], mosi_spi};  // MSB first
    end

    // ================================================
    // Bit counter and byte strobe
    // ================================================
    always_ff @(posedge sclk_spi or posedge cs_n_spi) begin
        if (cs_n_spi) begin
            bit_cnt       <= BIT_W'(`SPI_BYTE_W - 1);  // Next bit is bit 7
            rx_byte       <= '0;
            rx_byte_valid <= 1'b0;
        end else begin
            if (bit_cnt == '0) begin
                rx_byte       <= {shift_q, mosi_spi};  // Bit 0 sampled now
                rx_byte_valid <= 1'b1;
                bit_cnt       <= BIT_W'(`SPI_BYTE_W - 1);
            end else begin
                rx_byte_valid <= 1'b0;
                bit_cnt       <= bit_cnt - BIT_W'(1);
            end
        end
    end

endmodule

// File: spi_tx_shifter.sv
`timescale 1ns/10ps
`include "spi_accel_macros.svh"

module spi_tx_shifter (
    input  logic                   sclk_spi,  // SPI clock, mode 0
    input  logic                   cs_n_spi,  // Frame select, high clears
    input  logic [`SPI_BYTE_W-1:0] tx_byte,   // Byte for the next slot
    output logic                   miso_spi   // Serial data to master
);

    localparam int BIT_W = $clog2(`SPI_BYTE_W);

    logic [BIT_W-1:0]       bit_cnt;   // Falling edges seen in this slot
    logic [`SPI_BYTE_W-1:0] shift_q;   // Remaining bits of the current byte
    logic                   slot_end;  // Last falling edge of a slot

    // Falling edge n of the frame follows rising edge n, so the edge after
    // the 8th rising edge of a slot drives bit 7 of the next slot
    assign slot_end = (bit_cnt == BIT_W'(`SPI_BYTE_W - 1));

    // ================================================
    // Falling-edge output stage
    // ================================================
    always_ff @(negedge sclk_spi or posedge cs_n_spi) begin
        if (cs_n_spi) begin
            miso_spi <= 1'b0;  // Slot 0 shifts out zeros
            bit_cnt  <= '0;
            shift_q  <= '0;
        end else begin
            if (slot_end) begin
                // Slot boundary, take the staged byte
                miso_spi <= tx_byte[`SPI_BYTE_W-1];
                shift_q  <= {tx_byte[`SPI_BYTE_W-2:0], 1'b0};
                bit_cnt  <= '0;
            end else begin
                miso_spi <= shift_q[`SPI_BYTE_W-1];         // Next bit, MSB first
                shift_q  <= {shift_q[`SPI_BYTE_W-2:0], 1'b0};
                bit_cnt  <= bit_cnt + BIT_W'(1);
            end
        end
    end

endmodule

// File: spi_cmd_controller.sv
`timescale 1ns/10ps
`include "spi_accel_macros.svh"

module spi_cmd_controller
    import spi_proto_pkg::*, conv_buf_pkg::*;
(
    input  logic                   sclk_spi,
    input  logic                   cs_n_spi,             // High holds ST_IDLE
    input  logic [`SPI_BYTE_W-1:0] rx_byte,
    input  logic                   rx_byte_valid,
    input  logic                   busy_from_wrapper,    // Level, sampled as is
    input  logic                   done_from_wrapper,    // Level, sampled as is
    input  results_vec_t           results_from_wrapper,
    output logic [`SPI_BYTE_W-1:0] tx_byte,              // Byte for the next slot
    output logic                   wr_en,
    output buf_sel_e               wr_sel,
    output logic [`BYTE_CNT_W-1:0] wr_addr,
    output logic [`SPI_BYTE_W-1:0] wr_data,
    output logic                   start_to_wrapper      // One sclk_spi cycle
);

    localparam int CNT_W     = `BYTE_CNT_W;
    localparam int RES_IDX_W = $clog2(`RESULTS_BYTES);

    ctrl_state_e            state;
    logic [CNT_W-1:0]       byte_cnt;     // Data bytes stored or staged
    logic [CNT_W-1:0]       exp_cnt;      // Data bytes the command carries
    logic                   last_byte;    // Current write byte fills the buffer
    logic [RES_IDX_W-1:0]   res_sel;      // Result element of byte_cnt
    logic [`SPI_BYTE_W-1:0] status_byte;

    // ================================================
    // Decode helpers
    // ================================================
    assign last_byte = ((byte_cnt + CNT_W'(1)) == exp_cnt);

    // Result byte k sits in element N-1-k, the MSB end
    assign res_sel = RES_IDX_W'(`RESULTS_BYTES - 1) - byte_cnt[RES_IDX_W-1:0];

    assign status_byte = {{(`SPI_BYTE_W - 2){1'b0}}, done_from_wrapper, busy_from_wrapper};

    // Store port, write lands on the edge that sees the strobe
    assign wr_en   = (state == ST_RX_DATA) && rx_byte_valid;
    assign wr_addr = byte_cnt;  // Data byte k goes to address k
    assign wr_data = rx_byte;

    // ================================================
    // Command FSM
    // ================================================
    always_ff @(posedge sclk_spi or posedge cs_n_spi) begin
        if (cs_n_spi) begin
            state            <= ST_IDLE;
            byte_cnt         <= '0;
            exp_cnt          <= '0;
            wr_sel           <= BUF_NONE;
            tx_byte          <= '0;  // Slot 1 turnaround is 00h
            start_to_wrapper <= 1'b0;
        end else begin
            start_to_wrapper <= 1'b0;  // Pulse lasts one cycle
            if (rx_byte_valid) begin
                case (state)
                    ST_IDLE: begin
                        // byte_cnt is still 0 here
                        case (spi_cmd_e'(rx_byte))
                            CMD_WRITE_WEIGHTS: begin
                                wr_sel  <= BUF_WEIGHTS;
                                exp_cnt <= CNT_W'(`WEIGHTS_BYTES);
                                state   <= ST_RX_DATA;
                            end
                            CMD_WRITE_PATCH: begin
                                wr_sel  <= BUF_PATCH;
                                exp_cnt <= CNT_W'(`PATCH_BYTES);
                                state   <= ST_RX_DATA;
                            end
                            CMD_WRITE_BIASES: begin
                                wr_sel  <= BUF_BIASES;
                                exp_cnt <= CNT_W'(`BIASES_BYTES);
                                state   <= ST_RX_DATA;
                            end
                            CMD_START_PROC: begin
                                start_to_wrapper <= 1'b1;
                                state            <= ST_DONE;
                            end
                            CMD_READ_STATUS: begin
                                tx_byte  <= status_byte;  // Goes out in slot 2
                                exp_cnt  <= CNT_W'(1);
                                byte_cnt <= CNT_W'(1);
                                state    <= ST_TX_DATA;
                            end
                            CMD_READ_RESULTS: begin
                                tx_byte  <= results_from_wrapper[res_sel];  // Byte 0
                                exp_cnt  <= CNT_W'(`RESULTS_BYTES);
                                byte_cnt <= CNT_W'(1);
                                state    <= ST_TX_DATA;
                            end
                            default: begin
                                state <= ST_DONE;  // Unknown opcode, MISO stays low
                            end
                        endcase
                    end
                    ST_RX_DATA: begin
                        byte_cnt <= byte_cnt + CNT_W'(1);
                        if (last_byte) begin
                            state <= ST_DONE;  // Excess bytes dropped
                        end
                    end
                    ST_TX_DATA: begin
                        // Stage one slot ahead of the shifter
                        if (byte_cnt == exp_cnt) begin
                            tx_byte <= '0;  // Reply over, back to 00h
                            state   <= ST_DONE;
                        end else begin
                            tx_byte  <= results_from_wrapper[res_sel];
                            byte_cnt <= byte_cnt + CNT_W'(1);
                        end
                    end
                    default: begin
                        state <= ST_DONE;  // Wait for cs_n_spi to end the frame
                    end
                endcase
            end
        end
    end

endmodule

// File: conv_param_store.sv
`timescale 1ns/10ps
`include "spi_accel_macros.svh"

module conv_param_store
    import conv_buf_pkg::*;
(
    input  logic                   sclk_spi,
    input  logic                   wr_en,               // Write on this rising edge
    input  buf_sel_e               wr_sel,              // Target buffer
    input  logic [`BYTE_CNT_W-1:0] wr_addr,             // Always inside the buffer
    input  logic [`SPI_BYTE_W-1:0] wr_data,
    output patch_vec_t             patch_to_wrapper,
    output weights_vec_t           weights_to_wrapper,
    output biases_vec_t            biases_to_wrapper
);

    localparam int PATCH_AW   = $clog2(`PATCH_BYTES);
    localparam int WEIGHTS_AW = $clog2(`WEIGHTS_BYTES);
    localparam int BIASES_AW  = $clog2(`BIASES_BYTES);

    logic [`SPI_BYTE_W-1:0] patch_mem   [`PATCH_BYTES];
    logic [`SPI_BYTE_W-1:0] weights_mem [`WEIGHTS_BYTES];
    logic [`SPI_BYTE_W-1:0] biases_mem  [`BIASES_BYTES];

    // ================================================
    // Byte writes, contents kept across frames
    // ================================================
    always_ff @(posedge sclk_spi) begin
        if (wr_en) begin
            case (wr_sel)
                BUF_PATCH:   patch_mem[PATCH_AW'(wr_addr)]     <= wr_data;
                BUF_WEIGHTS: weights_mem[WEIGHTS_AW'(wr_addr)] <= wr_data;
                BUF_BIASES:  biases_mem[BIASES_AW'(wr_addr)]   <= wr_data;
                default: begin
                    // BUF_NONE, nothing addressed
                end
            endcase
        end
    end

    // ================================================
    // Packing, address 0 in the most significant byte
    // ================================================
    for (genvar i = 0; i < `PATCH_BYTES; i++) begin : g_patch
        assign patch_to_wrapper[`PATCH_BYTES-1-i] = patch_mem[i];
    end

    for (genvar i = 0; i < `WEIGHTS_BYTES; i++) begin : g_weights
        assign weights_to_wrapper[`WEIGHTS_BYTES-1-i] = weights_mem[i];
    end

    for (genvar i = 0; i < `BIASES_BYTES; i++) begin : g_biases
        assign biases_to_wrapper[`BIASES_BYTES-1-i] = biases_mem[i];
    end

endmodule

// File: spi_slave_top.sv
`timescale 1ns/10ps
`include "spi_accel_macros.svh"

module spi_slave_top
    import conv_buf_pkg::*;
(
    input  logic         sclk_spi,              // SPI clock, mode 0
    input  logic         cs_n_spi,              // Active low select, high resets
    input  logic         mosi_spi,
    output logic         miso_spi,
    output logic         start_to_wrapper,      // One sclk_spi cycle per START
    output patch_vec_t   patch_to_wrapper,
    output weights_vec_t weights_to_wrapper,
    output biases_vec_t  biases_to_wrapper,
    input  results_vec_t results_from_wrapper,
    input  logic         busy_from_wrapper,
    input  logic         done_from_wrapper
);

    logic [`SPI_BYTE_W-1:0] rx_byte;
    logic                   rx_byte_valid;
    logic [`SPI_BYTE_W-1:0] tx_byte;
    logic                   wr_en;
    buf_sel_e               wr_sel;
    logic [`BYTE_CNT_W-1:0] wr_addr;
    logic [`SPI_BYTE_W-1:0] wr_data;

    // ================================================
    // Serial front end
    // ================================================
    spi_rx_shifter spi_rx_shifter_inst (
        .sclk_spi      (sclk_spi),
        .cs_n_spi      (cs_n_spi),
        .mosi_spi      (mosi_spi),
        .rx_byte       (rx_byte),
        .rx_byte_valid (rx_byte_valid)
    );

    spi_tx_shifter spi_tx_shifter_inst (
        .sclk_spi (sclk_spi),
        .cs_n_spi (cs_n_spi),
        .tx_byte  (tx_byte),
        .miso_spi (miso_spi)
    );

    // ================================================
    // Command decode and parameter buffers
    // ================================================
    spi_cmd_controller spi_cmd_controller_inst (
        .sclk_spi             (sclk_spi),
        .cs_n_spi             (cs_n_spi),
        .rx_byte              (rx_byte),
        .rx_byte_valid        (rx_byte_valid),
        .busy_from_wrapper    (busy_from_wrapper),
        .done_from_wrapper    (done_from_wrapper),
        .results_from_wrapper (results_from_wrapper),
        .tx_byte              (tx_byte),
        .wr_en                (wr_en),
        .wr_sel               (wr_sel),
        .wr_addr              (wr_addr),
        .wr_data              (wr_data),
        .start_to_wrapper     (start_to_wrapper)
    );

    conv_param_store conv_param_store_inst (
        .sclk_spi           (sclk_spi),
        .wr_en              (wr_en),
        .wr_sel             (wr_sel),
        .wr_addr            (wr_addr),
        .wr_data            (wr_data),
        .patch_to_wrapper   (patch_to_wrapper),
        .weights_to_wrapper (weights_to_wrapper),
        .biases_to_wrapper  (biases_to_wrapper)
    );

endmodule

// File: spi_slave_assertions.sv
`timescale 1ns/10ps

module spi_slave_assertions
    import spi_proto_pkg::*;
(
    input logic        sclk_spi,
    input logic        cs_n_spi,
    input logic        start_to_wrapper,
    input logic        wr_en,
    input ctrl_state_e state
);

    int fail_cnt = 0;  // Failures seen, summed into the testbench total

    // ================================================
    // Controller strobes
    // ================================================

    // Start pulse is exactly one sclk_spi cycle
    start_one_cycle: assert property (@(posedge sclk_spi) disable iff (cs_n_spi)
        start_to_wrapper |=> !start_to_wrapper)
    else begin
        fail_cnt++;
        $error("start_to_wrapper high for two cycles");
    end

    no_write_in_reset: assert property (@(posedge sclk_spi)
        cs_n_spi |-> !wr_en)  // No store write outside a frame
    else begin
        fail_cnt++;
        $error("wr_en high while cs_n_spi is high");
    end

    // ================================================
    // Reset behavior
    // ================================================

    // First edge of every frame still sees the idle state
    idle_after_reset: assert property (@(posedge sclk_spi)
        $fell(cs_n_spi) |-> (state == ST_IDLE))
    else begin
        fail_cnt++;
        $error("controller not idle at frame start");
    end

endmodule

// File: tb_spi_slave.sv
`timescale 1ns/10ps
`include "spi_accel_macros.svh"

module tb_spi_slave
    import spi_proto_pkg::*;
();

    localparam int PATCH_W   = `PATCH_BYTES * `SPI_BYTE_W;
    localparam int WEIGHTS_W = `WEIGHTS_BYTES * `SPI_BYTE_W;
    localparam int BIASES_W  = `BIASES_BYTES * `SPI_BYTE_W;
    localparam int RESULTS_W = `RESULTS_BYTES * `SPI_BYTE_W;
    localparam int unsigned RAND_SEED = 95771;

    // Bytes over all frames of the run in main sequence order
    localparam int TEST_BYTES =
        (1 + `PATCH_BYTES) + (1 + `WEIGHTS_BYTES) + (1 + `BIASES_BYTES)  // Full writes
        + (1 + `PATCH_BYTES + 8) + 21 + 4 + 7                          // Excess and short
        + 2 * (4 + `RESULTS_BYTES) + 4 * 4                             // Result and status reads
        + 2 * 2 + 6 + 4 + 4;                                           // START, unknown, abort
    localparam int TEST_FRAMES    = 18;
    localparam int FRAME_BITS     = TEST_BYTES * 8 + TEST_FRAMES * 6;  // Tail and cs gap
    localparam int TIMEOUT_CYCLES = 2 * FRAME_BITS + 200;

    typedef logic [7:0] byte_q_t[$];

    logic                 sclk_spi;
    logic                 cs_n_spi;
    logic                 mosi_spi;
    logic                 miso_spi;
    logic                 start_to_wrapper;
    logic [PATCH_W-1:0]   patch_to_wrapper;
    logic [WEIGHTS_W-1:0] weights_to_wrapper;
    logic [BIASES_W-1:0]  biases_to_wrapper;
    logic [RESULTS_W-1:0] results_from_wrapper;
    logic                 busy_from_wrapper;
    logic                 done_from_wrapper;

    // Shadow of the three parameter buffers indexed by byte address
    logic [7:0] shadow_patch   [`PATCH_BYTES];
    logic [7:0] shadow_weights [`WEIGHTS_BYTES];
    logic [7:0] shadow_biases  [`BIASES_BYTES];

    logic [7:0] cmp_exp_q [$];   // Pending checks for the compare process
    logic [7:0] cmp_got_q [$];
    string      cmp_tag_q [$];
    int check_cnt = 0;
    int error_cnt = 0;
    int start_cnt = 0;           // Start pulses seen by the wrapper model
    int cycle_cnt = 0;

    spi_slave_top spi_slave_top_inst (
        .sclk_spi             (sclk_spi),
        .cs_n_spi             (cs_n_spi),
        .mosi_spi             (mosi_spi),
        .miso_spi             (miso_spi),
        .start_to_wrapper     (start_to_wrapper),
        .patch_to_wrapper     (patch_to_wrapper),
        .weights_to_wrapper   (weights_to_wrapper),
        .biases_to_wrapper    (biases_to_wrapper),
        .results_from_wrapper (results_from_wrapper),
        .busy_from_wrapper    (busy_from_wrapper),
        .done_from_wrapper    (done_from_wrapper)
    );

    bind spi_cmd_controller spi_slave_assertions spi_slave_assertions_inst (
        .sclk_spi         (sclk_spi),
        .cs_n_spi         (cs_n_spi),
        .start_to_wrapper (start_to_wrapper),
        .wr_en            (wr_en),
        .state            (state)
    );

    initial begin
        sclk_spi = 1'b0;
        forever #10 sclk_spi = ~sclk_spi;  // 20 ns period
    end

    // ================================================
    // Wrapper model
    // ================================================
    always @(negedge sclk_spi) begin
        if (start_to_wrapper === 1'b1) start_cnt++;  // One count per high cycle
    end

    task automatic set_wrapper_status(input logic done_lvl, input logic busy_lvl);
        done_from_wrapper <= done_lvl;
        busy_from_wrapper <= busy_lvl;
    endtask

    task automatic load_wrapper_results();
        logic [RESULTS_W-1:0] v;
        v = '0;
        for (int k = 0; k < `RESULTS_BYTES; k++) begin
            v = {v[RESULTS_W-9:0], 8'($urandom)};  // Byte 0 ends at the top
        end
        results_from_wrapper <= v;
    endtask

    // ================================================
    // SPI master, mode 0
    // ================================================
    // Drives n_bits of mosi_q MSB first and returns each complete MISO byte
    // Entered on a falling edge, so cs_n_spi falls right away
    task automatic run_frame(input byte_q_t mosi_q, input int n_bits, output byte_q_t miso_q);
        logic [7:0] tx_sh;
        logic [7:0] cap;
        int         idx;
        tx_sh  = '0;
        cap    = '0;
        miso_q = {};
        cs_n_spi <= 1'b0;
        for (int i = 0; i < n_bits; i++) begin
            if (i > 0) @(negedge sclk_spi);
            if ((i % 8) == 0) begin
                idx   = i / 8;
                tx_sh = (idx < mosi_q.size()) ? mosi_q[idx] : 8'h00;  // Pad with zeros
            end
            mosi_spi <= tx_sh[7];
            tx_sh = {tx_sh[6:0], 1'b0};
            @(posedge sclk_spi);
            cap = {cap[6:0], miso_spi};  // MISO only moves on falling edges
            if ((i % 8) == 7) miso_q.push_back(cap);
        end
        // One tail bit so the controller acts on the last byte strobe
        @(negedge sclk_spi);
        mosi_spi <= 1'b0;
        @(posedge sclk_spi);
        @(negedge sclk_spi);
        cs_n_spi <= 1'b1;
        repeat (2) @(negedge sclk_spi);  // Gap between frames
    endtask

    function automatic byte_q_t make_frame(input logic [7:0] cmd, input int n_rand);
        byte_q_t q;
        q = {};
        q.push_back(cmd);
        for (int k = 0; k < n_rand; k++) begin
            q.push_back(8'($urandom));
        end
        return q;
    endfunction

    // ================================================
    // Reference model
    // ================================================
    // Expected MISO slots and start pulses of one frame and the shadow buffer update
    function automatic void spi_expect(input byte_q_t mosi_q, input int n_bytes,
                                       input logic done_lvl, input logic busy_lvl,
                                       input logic [RESULTS_W-1:0] res_vec,
                                       output byte_q_t exp_q, output int exp_pulses);
        logic [7:0] cmd;
        int         n_data;
        exp_q      = {};
        exp_pulses = 0;
        for (int s = 0; s < n_bytes; s++) begin
            exp_q.push_back(8'h00);  // Zero unless a reply byte lands here
        end
        if (n_bytes == 0) return;
        cmd    = mosi_q[0];
        n_data = n_bytes - 1;  // Complete data bytes after the command
        case (cmd)
            CMD_WRITE_PATCH: begin
                for (int k = 0; k < n_data && k < `PATCH_BYTES; k++) shadow_patch[k] = mosi_q[1+k];
            end
            CMD_WRITE_WEIGHTS: begin
                for (int k = 0; k < n_data && k < `WEIGHTS_BYTES; k++) begin
                    shadow_weights[k] = mosi_q[1+k];
                end
            end
            CMD_WRITE_BIASES: begin
                for (int k = 0; k < n_data && k < `BIASES_BYTES; k++) shadow_biases[k] = mosi_q[1+k];
            end
            CMD_START_PROC: exp_pulses = 1;
            CMD_READ_STATUS: begin
                if (n_bytes > 2) exp_q[2] = {6'b0, done_lvl, busy_lvl};
            end
            CMD_READ_RESULTS: begin
                // Byte k is taken k bytes down from the MSB end
                for (int k = 0; k < `RESULTS_BYTES && 2 + k < n_bytes; k++) begin
                    exp_q[2+k] = 8'(res_vec >> (8 * (`RESULTS_BYTES - 1 - k)));
                end
            end
            default: ;  // Unknown opcode leaves all slots zero
        endcase
    endfunction

    // ================================================
    // Checking
    // ================================================
    task automatic queue_check(input string tag, input logic [7:0] exp_b, input logic [7:0] got_b);
        cmp_tag_q.push_back(tag);
        cmp_exp_q.push_back(exp_b);
        cmp_got_q.push_back(got_b);
    endtask

    always @(posedge sclk_spi) begin : compare_proc
        logic [7:0] exp_b;
        logic [7:0] got_b;
        string      tag;
        while (cmp_exp_q.size() > 0) begin
            exp_b = cmp_exp_q.pop_front();
            got_b = cmp_got_q.pop_front();
            tag   = cmp_tag_q.pop_front();
            check_cnt++;
            if (got_b !== exp_b) begin
                error_cnt++;
                $display("** Error @ %0d ns: %s expected %02h, got %02h", $time, tag, exp_b, got_b);
            end
        end
    end

    // Packed outputs hold byte 0 in the top byte
    task automatic check_buffers(input string tag);
        for (int k = 0; k < `PATCH_BYTES; k++) begin
            queue_check($sformatf("%s patch[%0d]", tag, k), shadow_patch[k],
                        8'(patch_to_wrapper >> (PATCH_W - 8 * (k + 1))));
        end
        for (int k = 0; k < `WEIGHTS_BYTES; k++) begin
            queue_check($sformatf("%s weights[%0d]", tag, k), shadow_weights[k],
                        8'(weights_to_wrapper >> (WEIGHTS_W - 8 * (k + 1))));
        end
        for (int k = 0; k < `BIASES_BYTES; k++) begin
            queue_check($sformatf("%s biases[%0d]", tag, k), shadow_biases[k],
                        8'(biases_to_wrapper >> (BIASES_W - 8 * (k + 1))));
        end
    endtask

    task automatic send_and_check(input string tag, input byte_q_t mosi_q, input int n_bits);
        byte_q_t got_q;
        byte_q_t exp_q;
        int      pulses_exp;
        int      start_before;
        start_before = start_cnt;
        run_frame(mosi_q, n_bits, got_q);
        spi_expect(mosi_q, n_bits / 8, done_from_wrapper, busy_from_wrapper,
                   results_from_wrapper, exp_q, pulses_exp);
        if (got_q.size() != exp_q.size()) begin
            error_cnt++;
            $display("Frame %s captured %0d bytes instead of %0d", tag, got_q.size(), exp_q.size());
        end else begin
            for (int s = 0; s < exp_q.size(); s++) begin
                queue_check($sformatf("%s slot %0d", tag, s), exp_q[s], got_q[s]);
            end
        end
        queue_check({tag, " start pulses"}, 8'(pulses_exp), 8'(start_cnt - start_before));
        check_buffers(tag);
    endtask

    // ================================================
    // Main sequence
    // ================================================
    initial begin : main_seq
        byte_q_t q;
        cs_n_spi             = 1'b1;  // Reset held from time 0
        mosi_spi             = 1'b0;
        busy_from_wrapper    = 1'b0;
        done_from_wrapper    = 1'b0;
        results_from_wrapper = '0;
        void'($urandom(RAND_SEED));
        repeat (2) @(negedge sclk_spi);

        q = make_frame(CMD_WRITE_PATCH, `PATCH_BYTES);
        send_and_check("patch full", q, 8 * q.size());
        q = make_frame(CMD_WRITE_WEIGHTS, `WEIGHTS_BYTES);
        send_and_check("weights full", q, 8 * q.size());
        q = make_frame(CMD_WRITE_BIASES, `BIASES_BYTES);
        send_and_check("biases full", q, 8 * q.size());
        q = make_frame(CMD_WRITE_PATCH, `PATCH_BYTES + 8);  // Eight bytes past the end
        send_and_check("patch excess", q, 8 * q.size());
        q = make_frame(CMD_WRITE_WEIGHTS, 20);
        send_and_check("weights short", q, 8 * q.size());
        q = make_frame(CMD_WRITE_BIASES, 3);
        send_and_check("biases short", q, 8 * q.size());
        q = make_frame(CMD_WRITE_PATCH, 6);
        send_and_check("patch short", q, 8 * q.size());

        repeat (2) begin
            load_wrapper_results();
            q = make_frame(CMD_READ_RESULTS, 3 + `RESULTS_BYTES);  // MOSI content is ignored
            send_and_check("read results", q, 8 * q.size());
        end

        for (int c = 0; c < 4; c++) begin
            set_wrapper_status(c[1], c[0]);
            q = make_frame(CMD_READ_STATUS, 3);
            send_and_check($sformatf("status %0d", c), q, 8 * q.size());
        end

        repeat (2) begin
            q = make_frame(CMD_START_PROC, 1);
            send_and_check("start", q, 8 * q.size());
        end

        q = make_frame(8'h55, 5);  // Not an opcode
        send_and_check("unknown opcode", q, 8 * q.size());
        q = make_frame(CMD_WRITE_PATCH, 3);
        send_and_check("abort", q, 3 * 8 + 3);  // cs_n_spi rises inside the fourth byte
        set_wrapper_status(1'b1, 1'b0);
        q = make_frame(CMD_READ_STATUS, 3);
        send_and_check("status after abort", q, 8 * q.size());

        repeat (2) @(posedge sclk_spi);  // Compare process drains its queue
        error_cnt += spi_slave_top_inst.spi_cmd_controller_inst.spi_slave_assertions_inst.fail_cnt;
        $display("Checks: %0d, errors: %0d", check_cnt, error_cnt);
        if (error_cnt == 0 && cmp_exp_q.size() == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    initial begin : watchdog
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge sclk_spi);
            cycle_cnt++;
        end
        $display("Timeout: run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
        $display("Test failures found");
        $finish;
    end

endmodule

// File: sim.f
+incdir+.
spi_proto_pkg.sv
conv_buf_pkg.sv
spi_rx_shifter.sv
spi_tx_shifter.sv
spi_cmd_controller.sv
conv_param_store.sv
spi_slave_top.sv
spi_slave_assertions.sv
tb_spi_slave.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the SPI slave testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module tb_spi_slave \
    --Mdir obj_dir -o tb_spi_slave_sim

# Raise the runtime error limit so assertion errors reach the testbench summary
./obj_dir/tb_spi_slave_sim +verilator+error+limit+1000 | tee sim.log

if grep -q "Test failures found" sim.log; then
    echo "Simulation FAILED, see sim.log"
    exit 1
fi
echo "Simulation finished without failures"
